/* hdl/fp_prep_pkg.sv */
/*
 * Formats, opcodes and packet types shared by the FPU operand pre-processing
 * stages and their testbench. Compile ahead of every file that imports it.
 */
package fp_prep_pkg;

    //////////////////////////////////////////////////
    // Formats
    localparam int FLEN       = 32;
    localparam int EXPO_WIDTH = 8;
    localparam int FRAC_WIDTH = 23;
    localparam int XLEN       = 32;

    typedef logic [FLEN-1:0] fp_word_t;
    typedef logic [XLEN-1:0] int_word_t;

    // Two's complement, top bit set when the difference is negative
    typedef logic signed [EXPO_WIDTH:0] expo_diff_t;

    localparam fp_word_t CANONICAL_NAN = 32'h7FC0_0000;

    //////////////////////////////////////////////////
    // Opcodes
    typedef enum logic [2:0] {
        FSGNJ     = 3'd0,
        FSGNJN    = 3'd1,
        FSGNJX    = 3'd2,
        FMIN      = 3'd3,
        FMAX      = 3'd4,
        FCVT_S_W  = 3'd5,
        FCVT_S_WU = 3'd6,
        FADD_PREP = 3'd7
    } fp_op_e;

    //////////////////////////////////////////////////
    // Packets
    typedef struct packed {
        logic is_inf;
        logic is_snan;
        logic is_qnan;
        logic is_zero;
        logic is_subnormal;
    } fp_special_t;

    // Operation offered to the issue stage
    typedef struct packed {
        fp_op_e    op;
        fp_word_t  rs1;
        fp_word_t  rs2;
        int_word_t int_rs1;
    } fp_issue_pkt_t;

    // Content of the issue stage register
    typedef struct packed {
        fp_op_e      op;
        fp_word_t    rs1;
        fp_word_t    rs2;
        fp_special_t rs1_special;
        fp_special_t rs2_special;
        logic        swap;
        expo_diff_t  expo_diff;
        expo_diff_t  expo_diff_neg;
        int_word_t   int_abs;
        logic        int_sign;
        logic        int_zero;
    } fp_stage_pkt_t;

    // Packet read by the downstream units
    typedef struct packed {
        fp_op_e      op;
        fp_special_t rs1_special;
        fp_special_t rs2_special;
        logic        swap;
        expo_diff_t  expo_diff;
        fp_word_t    result;
        logic        invalid;
        int_word_t   int_abs;
        logic        int_sign;
        logic        int_zero;
    } fp_prep_out_t;

endpackage

/* hdl/fp_class_detect.sv */
/*
 * Decodes one single-precision operand into its special-case flags.
 * Purely combinational, instantiated once per source operand.
 */
`timescale 1ns/1ps

module fp_class_detect (
    input  fp_prep_pkg::fp_word_t    i_operand,
    output fp_prep_pkg::fp_special_t o_special
);
    import fp_prep_pkg::*;

    logic [EXPO_WIDTH-1:0] expo;
    logic [FRAC_WIDTH-1:0] frac;
    logic                  expo_ones;
    logic                  expo_zero;
    logic                  frac_zero;

    // Field split
    assign expo = i_operand[FLEN-2 -: EXPO_WIDTH];
    assign frac = i_operand[FRAC_WIDTH-1:0];

    assign expo_ones = &expo;
    assign expo_zero = ~|expo;
    assign frac_zero = ~|frac;

    //////////////////////////////////////////////////
    // Special cases
    assign o_special.is_inf       = expo_ones & frac_zero;
    // Quiet bit is the top fraction bit
    assign o_special.is_snan      = expo_ones & ~frac_zero & ~frac[FRAC_WIDTH-1];
    assign o_special.is_qnan      = expo_ones & frac[FRAC_WIDTH-1];
    assign o_special.is_zero      = expo_zero & frac_zero;
    assign o_special.is_subnormal = expo_zero & ~frac_zero;

    // Downstream units decode the flags as mutually exclusive
    always_comb begin
        assert ($onehot0(o_special))
            else $error("fp_class_detect: more than one class flag for %h", i_operand);
    end

endmodule

/* hdl/fp_issue_stage.sv */
/*
 * First pre-processing stage. Classifies both operands, prepares the adder swap
 * and exponent difference and the int-to-float magnitude, then registers them.
 */
`timescale 1ns/1ps

module fp_issue_stage #(
    parameter bit ENABLE_SUBNORMAL = 1'b1
) (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_valid,
    input  fp_prep_pkg::fp_issue_pkt_t i_issue,
    input  logic                       i_out_ready,
    output logic                       o_ready,
    output logic                       o_stage_valid,
    output fp_prep_pkg::fp_stage_pkt_t o_stage
);
    import fp_prep_pkg::*;

    fp_special_t           rs1_special;
    fp_special_t           rs2_special;
    logic [EXPO_WIDTH-1:0] rs1_expo;
    logic [EXPO_WIDTH-1:0] rs2_expo;
    logic [FRAC_WIDTH-1:0] rs1_frac;
    logic [FRAC_WIDTH-1:0] rs2_frac;
    logic [EXPO_WIDTH:0]   rs1_expo_eff;
    logic [EXPO_WIDTH:0]   rs2_expo_eff;
    expo_diff_t            expo_diff;
    expo_diff_t            expo_diff_neg;
    logic                  swap;
    logic                  int_sign;
    int_word_t             int_abs;
    logic                  int_zero;
    fp_stage_pkt_t         stage_next;
    logic                  stage_valid;

    //////////////////////////////////////////////////
    // Classification
    fp_class_detect u_rs1_class (
        .i_operand (i_issue.rs1),
        .o_special (rs1_special)
    );

    fp_class_detect u_rs2_class (
        .i_operand (i_issue.rs2),
        .o_special (rs2_special)
    );

    //////////////////////////////////////////////////
    // Exponent difference and swap
    assign rs1_expo = i_issue.rs1[FLEN-2 -: EXPO_WIDTH];
    assign rs2_expo = i_issue.rs2[FLEN-2 -: EXPO_WIDTH];
    assign rs1_frac = i_issue.rs1[FRAC_WIDTH-1:0];
    assign rs2_frac = i_issue.rs2[FRAC_WIDTH-1:0];

    // A subnormal behaves as exponent 1 when subnormals are supported
    assign rs1_expo_eff = {1'b0, rs1_expo} +
                          {{EXPO_WIDTH{1'b0}}, ENABLE_SUBNORMAL & rs1_special.is_subnormal};
    assign rs2_expo_eff = {1'b0, rs2_expo} +
                          {{EXPO_WIDTH{1'b0}}, ENABLE_SUBNORMAL & rs2_special.is_subnormal};

    assign expo_diff     = expo_diff_t'(rs1_expo_eff - rs2_expo_eff);
    assign expo_diff_neg = expo_diff_t'(rs2_expo_eff - rs1_expo_eff);

    // Swap when rs2 has the larger magnitude, fraction breaks an exponent tie
    always_comb begin
        if (expo_diff[EXPO_WIDTH]) begin
            swap = 1'b1;
        end else if (|expo_diff[EXPO_WIDTH-1:0]) begin
            swap = 1'b0;
        end else begin
            swap = rs1_frac < rs2_frac;
        end
    end

    //////////////////////////////////////////////////
    // Integer operand for int-to-float
    // Only the signed conversion treats the top bit as a sign
    assign int_sign = (i_issue.op == FCVT_S_W) & i_issue.int_rs1[XLEN-1];
    assign int_abs  = int_sign ? -i_issue.int_rs1 : i_issue.int_rs1;
    assign int_zero = ~|i_issue.int_rs1;

    always_comb begin
        stage_next.op            = i_issue.op;
        stage_next.rs1           = i_issue.rs1;
        stage_next.rs2           = i_issue.rs2;
        stage_next.rs1_special   = rs1_special;
        stage_next.rs2_special   = rs2_special;
        stage_next.swap          = swap;
        stage_next.expo_diff     = expo_diff;
        stage_next.expo_diff_neg = expo_diff_neg;
        stage_next.int_abs       = int_abs;
        stage_next.int_sign      = int_sign;
        stage_next.int_zero      = int_zero;
    end

    //////////////////////////////////////////////////
    // Stage register and back-pressure
    // Accept when empty or when the current packet leaves this cycle
    assign o_ready = ~stage_valid | i_out_ready;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            stage_valid <= 1'b0;
        end else if (o_ready) begin
            stage_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready) begin
            o_stage <= stage_next;
        end
    end

    assign o_stage_valid = stage_valid;

    // A stalled packet must reach the consumer unchanged
    stall_holds_packet: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (stage_valid && !i_out_ready) |=> (stage_valid && $stable(o_stage))
    ) else $error("fp_issue_stage: packet changed while stalled");

endmodule

/* hdl/fp_result_stage.sv */
/*
 * Second pre-processing stage, combinational. Completes sign injection and
 * min/max and selects the absolute exponent difference for the adder.
 */
`timescale 1ns/1ps

module fp_result_stage (
    input  fp_prep_pkg::fp_stage_pkt_t i_stage,
    output fp_prep_pkg::fp_prep_out_t  o_out
);
    import fp_prep_pkg::*;

    fp_word_t   rs1;
    fp_word_t   rs2;
    logic       rs1_sign;
    logic       rs2_sign;
    logic       rs1_nan;
    logic       rs2_nan;
    logic       is_minmax;
    expo_diff_t expo_diff_abs;
    logic       expo_field_differs;
    logic       rs1_mag_lt;
    logic       rs1_lt;
    fp_word_t   minmax_result;
    fp_word_t   result;

    assign rs1      = i_stage.rs1;
    assign rs2      = i_stage.rs2;
    assign rs1_sign = rs1[FLEN-1];
    assign rs2_sign = rs2[FLEN-1];
    assign rs1_nan  = i_stage.rs1_special.is_snan | i_stage.rs1_special.is_qnan;
    assign rs2_nan  = i_stage.rs2_special.is_snan | i_stage.rs2_special.is_qnan;

    assign is_minmax = (i_stage.op == FMIN) | (i_stage.op == FMAX);

    //////////////////////////////////////////////////
    // Exponent difference
    assign expo_diff_abs = i_stage.expo_diff[EXPO_WIDTH] ? i_stage.expo_diff_neg
                                                         : i_stage.expo_diff;

    //////////////////////////////////////////////////
    // Min/max ordering
    // Subnormal and exponent-1 operands share an effective exponent,
    // there the raw exponent field decides instead of the fraction
    assign expo_field_differs = rs1[FLEN-2 -: EXPO_WIDTH] != rs2[FLEN-2 -: EXPO_WIDTH];

    always_comb begin
        if (expo_diff_abs == '0 && expo_field_differs) begin
            rs1_mag_lt = rs1[FLEN-2 -: EXPO_WIDTH] < rs2[FLEN-2 -: EXPO_WIDTH];
        end else begin
            rs1_mag_lt = i_stage.swap;
        end
    end

    // Negative sign wins on mixed signs, so -0 sits below +0
    assign rs1_lt = (rs1_sign != rs2_sign) ? rs1_sign : (rs1_sign ^ rs1_mag_lt);

    always_comb begin
        if (rs1_nan && rs2_nan) begin
            minmax_result = CANONICAL_NAN;
        end else if (rs1_nan) begin
            minmax_result = rs2;
        end else if (rs2_nan) begin
            minmax_result = rs1;
        end else if (i_stage.op == FMAX) begin
            minmax_result = rs1_lt ? rs2 : rs1;
        end else begin
            minmax_result = rs1_lt ? rs1 : rs2;
        end
    end

    //////////////////////////////////////////////////
    // Result select
    always_comb begin
        case (i_stage.op)
            FSGNJ:      result = {rs2_sign, rs1[FLEN-2:0]};
            FSGNJN:     result = {~rs2_sign, rs1[FLEN-2:0]};
            FSGNJX:     result = {rs1_sign ^ rs2_sign, rs1[FLEN-2:0]};
            FMIN, FMAX: result = minmax_result;
            default:    result = '0;
        endcase
    end

    assign o_out.op          = i_stage.op;
    assign o_out.rs1_special = i_stage.rs1_special;
    assign o_out.rs2_special = i_stage.rs2_special;
    assign o_out.swap        = i_stage.swap;
    assign o_out.expo_diff   = expo_diff_abs;
    assign o_out.result      = result;
    assign o_out.invalid     = is_minmax &
                               (i_stage.rs1_special.is_snan | i_stage.rs2_special.is_snan);
    assign o_out.int_abs     = i_stage.int_abs;
    assign o_out.int_sign    = i_stage.int_sign;
    assign o_out.int_zero    = i_stage.int_zero;

    // Only min/max may raise the invalid flag
    always_comb begin
        assert (!o_out.invalid || is_minmax)
            else $error("fp_result_stage: invalid raised for op %0d", i_stage.op);
    end

endmodule

/* hdl/fp_prep_top.sv */
/*
 * Operand pre-processing in front of the FPU. Two stages with one-cycle latency
 * and level back-pressure from a single downstream ready.
 */
`timescale 1ns/1ps

module fp_prep_top #(
    parameter bit ENABLE_SUBNORMAL = 1'b1
) (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_valid,
    input  fp_prep_pkg::fp_issue_pkt_t i_issue,
    input  logic                       i_out_ready,
    output logic                       o_ready,
    output logic                       o_valid,
    output fp_prep_pkg::fp_prep_out_t  o_out
);
    import fp_prep_pkg::*;

    fp_stage_pkt_t stage;
    logic          stage_valid;

    //////////////////////////////////////////////////
    // Issue stage
    fp_issue_stage #(
        .ENABLE_SUBNORMAL (ENABLE_SUBNORMAL)
    ) u_issue_stage (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (i_valid),
        .i_issue       (i_issue),
        .i_out_ready   (i_out_ready),
        .o_ready       (o_ready),
        .o_stage_valid (stage_valid),
        .o_stage       (stage)
    );

    //////////////////////////////////////////////////
    // Result stage
    fp_result_stage u_result_stage (
        .i_stage (stage),
        .o_out   (o_out)
    );

    // The result stage adds no delay, so the stage valid is the output valid
    assign o_valid = stage_valid;

endmodule

/* include/fp_prep_model.svh */
/*
 * Reference model of the pre-processing output packet. Include inside the
 * testbench module after importing fp_prep_pkg.
 */
`ifndef FP_PREP_MODEL_SVH
`define FP_PREP_MODEL_SVH

function automatic fp_special_t classify_operand(fp_word_t w);
    fp_special_t s;
    logic [7:0]  e;
    logic [22:0] f;
    e = w[30:23];
    f = w[22:0];
    s.is_inf       = (e == 8'hFF) && (f == 0);
    s.is_snan      = (e == 8'hFF) && (f != 0) && !f[22];
    s.is_qnan      = (e == 8'hFF) && f[22];
    s.is_zero      = (e == 8'h00) && (f == 0);
    s.is_subnormal = (e == 8'h00) && (f != 0);
    return s;
endfunction

// Unsigned key that sorts like the float value with -0 below +0
function automatic logic [31:0] order_key(fp_word_t w);
    return w[31] ? ~w : (w | 32'h8000_0000);
endfunction

function automatic fp_prep_out_t predict_packet(fp_issue_pkt_t p, bit en_sub);
    fp_prep_out_t o;
    int           e1;
    int           e2;
    longint       int_val;
    logic         nan1;
    logic         nan2;
    logic         lt;
    o = '0;
    o.op          = p.op;
    o.rs1_special = classify_operand(p.rs1);
    o.rs2_special = classify_operand(p.rs2);
    e1 = int'(p.rs1[30:23]) + int'(en_sub && o.rs1_special.is_subnormal);
    e2 = int'(p.rs2[30:23]) + int'(en_sub && o.rs2_special.is_subnormal);
    o.swap      = (e1 < e2) || ((e1 == e2) && (p.rs1[22:0] < p.rs2[22:0]));
    o.expo_diff = expo_diff_t'((e1 > e2) ? (e1 - e2) : (e2 - e1));
    // Signed conversion reads the operand as two's complement
    o.int_sign  = (p.op == FCVT_S_W) && ($signed(p.int_rs1) < 0);
    int_val     = o.int_sign ? -longint'($signed(p.int_rs1)) : longint'(p.int_rs1);
    o.int_abs   = int_word_t'(int_val);
    o.int_zero  = (p.int_rs1 == 0);
    nan1 = o.rs1_special.is_snan || o.rs1_special.is_qnan;
    nan2 = o.rs2_special.is_snan || o.rs2_special.is_qnan;
    lt   = order_key(p.rs1) < order_key(p.rs2);
    case (p.op)
        FSGNJ:  o.result = {p.rs2[31], p.rs1[30:0]};
        FSGNJN: o.result = {!p.rs2[31], p.rs1[30:0]};
        FSGNJX: o.result = {p.rs1[31] ^ p.rs2[31], p.rs1[30:0]};
        FMIN, FMAX: begin
            if (nan1 && nan2) begin
                o.result = CANONICAL_NAN;
            end else if (nan1 || nan2) begin
                o.result = nan1 ? p.rs2 : p.rs1;
            end else begin
                o.result = ((p.op == FMIN) == lt) ? p.rs1 : p.rs2;
            end
            o.invalid = o.rs1_special.is_snan || o.rs2_special.is_snan;
        end
        default: o.result = '0;
    endcase
    return o;
endfunction

`endif

/* tb/tb_fp_prep.sv */
/*
 * Random-traffic testbench for the FPU operand pre-processing stages.
 * Every accepted operation is predicted by the model and checked when consumed.
 */
`timescale 1ns/1ps

module tb_fp_prep;
    import fp_prep_pkg::*;

    `include "fp_prep_model.svh"

    localparam int NUM_OPS       = 400;
    localparam int RUN_TIMEOUT   = 20000;
    localparam int FILL_TIMEOUT  = 20;
    localparam int DRAIN_TIMEOUT = 200;
    localparam int STALL_CYCLES  = 12;

    logic          clk = 1'b0;
    logic          i_rst_n;
    logic          i_valid;
    fp_issue_pkt_t i_issue;
    logic          i_out_ready;
    logic          o_ready;
    logic          o_valid;
    fp_prep_out_t  o_out;

    integer        seed;
    string         cur_test;
    int            num_tests;
    int            num_checks;
    int            num_errors;
    int            checks_at_start;
    int            errors_at_start;
    int            num_accepted;
    int            num_consumed;
    bit            timed_out;
    fp_prep_out_t  exp_q[$];
    fp_word_t      special_vals[12];

    // Carried from one rising edge to the next
    bit            accepted_last;
    bit            hold_pending;
    fp_prep_out_t  held_out;

    fp_prep_top #(
        .ENABLE_SUBNORMAL (1'b1)
    ) u_dut (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .i_issue     (i_issue),
        .i_out_ready (i_out_ready),
        .o_ready     (o_ready),
        .o_valid     (o_valid),
        .o_out       (o_out)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // Checking
    task automatic check_value(string field, logic [127:0] expected, logic [127:0] actual);
        num_checks++;
        if (expected !== actual) begin
            num_errors++;
            $display("FAILED %s %s: expected 0x%0h, actual 0x%0h",
                     cur_test, field, expected, actual);
        end
    endtask

    // Fields that the op leaves undefined are skipped
    task automatic compare_packet(fp_prep_out_t e, fp_prep_out_t a);
        check_value("op", 128'(e.op), 128'(a.op));
        check_value("rs1_special", 128'(e.rs1_special), 128'(a.rs1_special));
        check_value("rs2_special", 128'(e.rs2_special), 128'(a.rs2_special));
        check_value("invalid", 128'(e.invalid), 128'(a.invalid));
        case (e.op)
            FSGNJ, FSGNJN, FSGNJX, FMIN, FMAX: begin
                check_value("result", 128'(e.result), 128'(a.result));
            end
            FADD_PREP: begin
                check_value("swap", 128'(e.swap), 128'(a.swap));
                check_value("expo_diff", 128'(e.expo_diff), 128'(a.expo_diff));
            end
            FCVT_S_W, FCVT_S_WU: begin
                check_value("int_abs", 128'(e.int_abs), 128'(a.int_abs));
                check_value("int_sign", 128'(e.int_sign), 128'(a.int_sign));
                check_value("int_zero", 128'(e.int_zero), 128'(a.int_zero));
            end
            default: ;
        endcase
    endtask

    // Scoreboard work at a rising edge before the DUT registers update
    task automatic sample_edge();
        // The stage holds an operation exactly while one is pending
        check_value("o_ready", 128'(exp_q.size() == 0 || i_out_ready), 128'(o_ready));
        if (accepted_last) begin
            check_value("o_valid after accept", 128'(1'b1), 128'(o_valid));
        end
        if (hold_pending) begin
            check_value("o_valid while stalled", 128'(1'b1), 128'(o_valid));
            check_value("o_out while stalled", 128'(held_out), 128'(o_out));
        end
        if (o_valid && i_out_ready) begin
            if (exp_q.size() == 0) begin
                num_errors++;
                $display("ERROR: %s consumed an output with no operation pending", cur_test);
            end else begin
                compare_packet(exp_q.pop_front(), o_out);
            end
            num_consumed++;
        end
        accepted_last = i_valid && o_ready;
        if (accepted_last) begin
            exp_q.push_back(predict_packet(i_issue, 1'b1));
            num_accepted++;
        end
        hold_pending = o_valid && !i_out_ready;
        held_out     = o_out;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        sample_edge();
        @(negedge clk);
    endtask

    task automatic begin_test(string name);
        cur_test        = name;
        checks_at_start = num_checks;
        errors_at_start = num_errors;
    endtask

    task automatic finish_test();
        num_tests++;
        $display("TEST %s: %0d checks, %0d errors", cur_test,
                 num_checks - checks_at_start, num_errors - errors_at_start);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic fp_word_t pick_operand();
        if (rand_below(100) < 30) begin
            return special_vals[4'(rand_below(12))];
        end
        return fp_word_t'($random(seed));
    endfunction

    function automatic fp_issue_pkt_t random_issue();
        fp_issue_pkt_t p;
        p.op  = fp_op_e'(3'(rand_below(8)));
        p.rs1 = pick_operand();
        p.rs2 = pick_operand();
        // Shared exponent now and then so the fraction decides
        if (rand_below(100) < 20) begin
            p.rs2[30:23] = p.rs1[30:23];
        end
        p.int_rs1 = int_word_t'($random(seed));
        if (rand_below(20) == 0) begin
            p.int_rs1 = '0;
        end
        return p;
    endfunction

    initial begin
        int cycles;
        i_rst_n       = 1'b0;
        i_valid       = 1'b0;
        i_issue       = '0;
        i_out_ready   = 1'b0;
        seed          = 32'h6f0d_1bd8;
        cur_test      = "reset";
        num_tests     = 0;
        num_checks    = 0;
        num_errors    = 0;
        num_accepted  = 0;
        num_consumed  = 0;
        timed_out     = 1'b0;
        accepted_last = 1'b0;
        hold_pending  = 1'b0;
        held_out      = '0;
        // Zeros, infinities, quiet and signalling NaNs, subnormals, smallest normal
        special_vals = '{32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000,
                         32'h7FC0_0000, 32'hFFC0_0001, 32'h7F80_0001, 32'hFFA0_0000,
                         32'h0000_0001, 32'h807F_FFFF, 32'h0040_0000, 32'h0080_0000};

        repeat (8) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        begin_test("reset_state");
        check_value("o_valid", 128'(1'b0), 128'(o_valid));
        check_value("o_ready", 128'(1'b1), 128'(o_ready));
        finish_test();

        begin_test("random_traffic");
        cycles = 0;
        while (num_accepted < NUM_OPS && !timed_out) begin
            i_out_ready = rand_below(100) < 70;
            i_valid     = rand_below(100) < 60;
            i_issue     = random_issue();
            next_cycle();
            cycles++;
            if (cycles >= RUN_TIMEOUT) begin
                timed_out = 1'b1;
                $display("ERROR: random_traffic timed out after %0d of %0d operations",
                         num_accepted, NUM_OPS);
            end
        end
        finish_test();

        if (!timed_out) begin
            begin_test("long_stall");
            i_out_ready = 1'b0;
            i_valid     = 1'b1;
            i_issue     = random_issue();
            cycles      = 0;
            while (!o_valid && cycles < FILL_TIMEOUT) begin
                next_cycle();
                cycles++;
            end
            i_valid = 1'b0;
            if (!o_valid) begin
                timed_out = 1'b1;
                $display("ERROR: long_stall never saw the stage fill");
            end
            // Downstream holds off and the packet must sit still
            repeat (STALL_CYCLES) begin
                next_cycle();
                check_value("o_ready while stalled", 128'(1'b0), 128'(o_ready));
            end
            finish_test();
        end

        if (!timed_out) begin
            begin_test("drain");
            i_valid     = 1'b0;
            i_out_ready = 1'b1;
            cycles      = 0;
            while ((o_valid || exp_q.size() != 0) && cycles < DRAIN_TIMEOUT) begin
                next_cycle();
                cycles++;
            end
            if (o_valid || exp_q.size() != 0) begin
                timed_out = 1'b1;
                $display("ERROR: drain timed out with %0d operations still pending",
                         exp_q.size());
            end
            check_value("consumed count", 128'(num_accepted), 128'(num_consumed));
            // Empty stage with downstream not ready must still accept
            i_out_ready = 1'b0;
            next_cycle();
            check_value("o_valid when empty", 128'(1'b0), 128'(o_valid));
            check_value("o_ready when empty", 128'(1'b1), 128'(o_ready));
            finish_test();
        end

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d operations",
                 num_tests, num_checks, num_errors, num_accepted);
        if (num_errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
hdl/fp_prep_pkg.sv
hdl/fp_class_detect.sv
hdl/fp_issue_stage.sv
hdl/fp_result_stage.sv
hdl/fp_prep_top.sv
tb/tb_fp_prep.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_fp_prep \
    -Mdir obj_dir -o sim_fp_prep || { echo "Build failed"; exit 1; }

output="$(./obj_dir/sim_fp_prep 2>&1)"
printf '%s\n' "$output"

printf '%s\n' "$output" | grep -qx "RESULT: PASS" && exit 0 || exit 1
